/* testbench/cache_chk.sv */
`timescale 1ns/10ps

module cache_chk (
    input logic clk,
    input logic rst,
    input logic mem_read,
    input logic mem_write,
    input logic mem_resp,
    input logic pmem_read,
    input logic pmem_write,
    input logic pmem_resp
);

    int   violations = 0;
    logic idle_since_reset; // no request seen since reset.

    always_ff @(posedge clk) begin
        if (rst) begin
            idle_since_reset <= 1'b1;
        end else if (mem_read || mem_write) begin
            idle_since_reset <= 1'b0;
        end
    end

    quiet_after_reset: assert property (@(posedge clk) disable iff (rst)
        idle_since_reset |-> !mem_resp && !pmem_read && !pmem_write)
        else begin
            violations++;
            $error("cache active after reset before any request");
        end

    pmem_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(pmem_read && pmem_write))
        else begin
            violations++;
            $error("pmem_read and pmem_write high together");
        end

    pmem_read_held: assert property (@(posedge clk) disable iff (rst)
        pmem_read && !pmem_resp |=> pmem_read)
        else begin
            violations++;
            $error("pmem_read dropped before pmem_resp");
        end

    pmem_write_held: assert property (@(posedge clk) disable iff (rst)
        pmem_write && !pmem_resp |=> pmem_write)
        else begin
            violations++;
            $error("pmem_write dropped before pmem_resp");
        end

    resp_one_cycle: assert property (@(posedge clk) disable iff (rst)
        mem_resp |=> !mem_resp)
        else begin
            violations++;
            $error("mem_resp longer than one cycle");
        end

    resp_with_request: assert property (@(posedge clk) disable iff (rst)
        mem_resp |-> mem_read || mem_write)
        else begin
            violations++;
            $error("mem_resp without a pending request");
        end

endmodule : cache_chk

bind cache cache_chk i_cache_chk (
    .clk        (clk),
    .rst        (rst),
    .mem_read   (mem_read),
    .mem_write  (mem_write),
    .mem_resp   (mem_resp),
    .pmem_read  (pmem_read),
    .pmem_write (pmem_write),
    .pmem_resp  (pmem_resp)
);

/* testbench/cache_tb.sv */
`timescale 1ns/10ps

module cache_tb;

    localparam int addr_w       = 16;
    localparam int line_w       = 64;
    localparam int index_w      = 2;
    localparam int offset_w     = $clog2(line_w / 8);
    localparam int resp_timeout = 40;

    logic              clk;
    logic              rst;
    logic              mem_read;
    logic              mem_write;
    logic [addr_w-1:0] mem_address;
    logic [line_w-1:0] mem_wdata;
    logic              mem_resp;
    logic [line_w-1:0] mem_rdata;
    logic              pmem_read;
    logic              pmem_write;
    logic [addr_w-1:0] pmem_address;
    logic [line_w-1:0] pmem_wdata;
    logic              pmem_resp;
    logic [line_w-1:0] pmem_rdata;

    logic [line_w-1:0] ref_lines [logic [addr_w-1:0]]; // last line written per address.
    logic [addr_w-1:0] wb_addrs [$];
    logic [line_w-1:0] wb_lines [$];
    int                pmem_read_cycles  = 0;
    int                pmem_write_cycles = 0;
    int                errors            = 0;
    int                timeouts          = 0;
    bit                aborted           = 1'b0;
    integer            seed;

    tb_clock #(.period(8.0)) i_clock (.clk(clk));

    cache #(
        .addr_w  (addr_w),
        .line_w  (line_w),
        .index_w (index_w)
    ) i_cache (
        .clk          (clk),
        .rst          (rst),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_address  (mem_address),
        .mem_wdata    (mem_wdata),
        .pmem_resp    (pmem_resp),
        .pmem_rdata   (pmem_rdata),
        .mem_resp     (mem_resp),
        .mem_rdata    (mem_rdata),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_address (pmem_address),
        .pmem_wdata   (pmem_wdata)
    );

    lower_memory_model #(
        .addr_w (addr_w),
        .line_w (line_w)
    ) i_memory (
        .clk          (clk),
        .rst          (rst),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_address (pmem_address),
        .pmem_wdata   (pmem_wdata),
        .pmem_resp    (pmem_resp),
        .pmem_rdata   (pmem_rdata)
    );

    // lower-memory traffic sampled mid-cycle.
    always @(negedge clk) begin
        if (!rst) begin
            if (pmem_read) begin
                pmem_read_cycles++;
            end
            if (pmem_write) begin
                pmem_write_cycles++;
                if (pmem_resp) begin
                    wb_addrs.push_back(pmem_address);
                    wb_lines.push_back(pmem_wdata);
                end
            end
        end
    end

    function automatic logic [addr_w-1:0] line_addr(int tag, int set);
        return addr_w'((tag << (index_w + offset_w)) | (set << offset_w));
    endfunction

    // unwritten lines hold the memory's address pattern.
    function automatic logic [line_w-1:0] expected_line(logic [addr_w-1:0] addr);
        logic [line_w-1:0] line;
        if (ref_lines.exists(addr)) begin
            return ref_lines[addr];
        end
        line = '0;
        for (int i = 0; i < line_w / addr_w; i++) begin
            line[i*addr_w +: addr_w] = ~addr ^ addr_w'(i * 'h0101);
        end
        return line;
    endfunction

    task automatic report_mismatch(string msg);
        errors++;
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endtask

    // one request held until mem_resp. cycles counts edges to the response.
    task automatic access(input logic write, input logic [addr_w-1:0] addr,
                          input logic [line_w-1:0] wdata, output int cycles);
        int waited;
        cycles = 0;
        waited = 0;
        if (aborted) begin
            return;
        end
        mem_read    = !write;
        mem_write   = write;
        mem_address = addr;
        mem_wdata   = wdata;
        while (waited < resp_timeout) begin
            @(negedge clk);
            if (mem_resp) begin
                break;
            end
            waited++;
        end
        if (waited >= resp_timeout) begin
            $display("timeout: no mem_resp within %0d cycles for address %h", resp_timeout, addr);
            timeouts++;
            aborted = 1'b1;
            @(posedge clk);
            #1;
            mem_read  = 1'b0;
            mem_write = 1'b0;
            return;
        end
        cycles = waited;
        if (write) begin
            ref_lines[addr] = wdata;
        end else begin
            assert (mem_rdata === expected_line(addr))
                else report_mismatch($sformatf("read %h returned %h, expected %h",
                                               addr, mem_rdata, expected_line(addr)));
        end
        @(posedge clk);
        #1;
        mem_read  = 1'b0;
        mem_write = 1'b0;
    endtask

    task automatic read_check(input logic [addr_w-1:0] addr);
        int cycles;
        access(1'b0, addr, '0, cycles);
    endtask

    task automatic write_store(input logic [addr_w-1:0] addr, input logic [line_w-1:0] data);
        int cycles;
        access(1'b1, addr, data, cycles);
    endtask

    initial begin : stimulus
        int                cycles;
        int                reads_before;
        int                writes_before;
        int                wb_before;
        int                r_tag;
        int                r_set;
        logic [31:0]       hi;
        logic [31:0]       lo;
        logic [line_w-1:0] d1;
        seed        = 32'hac7d;
        rst         = 1'b1;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        mem_address = '0;
        mem_wdata   = '0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (3) @(posedge clk); // idle cycles with no request.
        #1;

        // a miss and then a repeated read that must hit in one cycle.
        read_check(line_addr(1, 0));
        reads_before = pmem_read_cycles;
        access(1'b0, line_addr(1, 0), '0, cycles);
        if (!aborted) begin
            assert (cycles == 1)
                else report_mismatch($sformatf("hit took %0d cycles", cycles));
            assert (pmem_read_cycles == reads_before)
                else report_mismatch("hit caused a lower-memory read");
        end
        write_store(line_addr(1, 0), 64'h0123_4567_89ab_cdef);
        read_check(line_addr(1, 0));

        // three writes to set 1 leave the first line as the PLRU victim.
        d1 = 64'hd1d1_0001_a5a5_5a5a;
        write_store(line_addr(1, 1), d1);
        write_store(line_addr(2, 1), 64'hd2d2_0002_3c3c_c3c3);
        wb_before = wb_addrs.size();
        write_store(line_addr(3, 1), 64'hd3d3_0003_0f0f_f0f0);
        if (!aborted) begin
            assert (wb_addrs.size() == wb_before + 1)
                else report_mismatch("dirty victim not written back once");
            if (wb_addrs.size() > wb_before) begin
                assert (wb_addrs[wb_before] == line_addr(1, 1))
                    else report_mismatch($sformatf("write-back to %h", wb_addrs[wb_before]));
                assert (wb_lines[wb_before] == d1)
                    else report_mismatch($sformatf("write-back data %h", wb_lines[wb_before]));
            end
        end
        read_check(line_addr(1, 1));

        // clean victims leave memory alone.
        writes_before = pmem_write_cycles;
        read_check(line_addr(1, 2));
        read_check(line_addr(2, 2));
        read_check(line_addr(3, 2));
        if (!aborted) begin
            assert (pmem_write_cycles == writes_before)
                else report_mismatch("clean eviction wrote to lower memory");
        end

        // mixed traffic over a few tags in every set.
        repeat (24) begin
            r_tag = $unsigned($random(seed)) % 6;
            r_set = $unsigned($random(seed)) % 4;
            hi    = $random(seed);
            lo    = $random(seed);
            if (hi[0]) begin
                write_store(line_addr(r_tag, r_set), {hi, lo});
            end else begin
                read_check(line_addr(r_tag, r_set));
            end
        end

        repeat (2) @(posedge clk);
        $display("errors: %0d check, %0d timeout, %0d assertion",
                 errors, timeouts, i_cache.i_cache_chk.violations);
        if (errors == 0 && timeouts == 0 && i_cache.i_cache_chk.violations == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end : stimulus

endmodule : cache_tb

/* testbench/lower_memory_model.sv */
`timescale 1ns/10ps

module lower_memory_model #(
    parameter int addr_w = 32,
    parameter int line_w = 256
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              pmem_read,
    input  logic              pmem_write,
    input  logic [addr_w-1:0] pmem_address,
    input  logic [line_w-1:0] pmem_wdata,
    output logic              pmem_resp,
    output logic [line_w-1:0] pmem_rdata
);

    logic [line_w-1:0] lines [logic [addr_w-1:0]];
    integer            seed;
    int                latency;

    // every chunk mixes in the full address.
    function automatic logic [line_w-1:0] fill_line(logic [addr_w-1:0] addr);
        logic [line_w-1:0] line;
        line = '0;
        for (int i = 0; i < line_w / addr_w; i++) begin
            line[i*addr_w +: addr_w] = ~addr ^ addr_w'(i * 'h0101);
        end
        return line;
    endfunction

    initial begin
        seed       = 32'hac7d;
        pmem_resp  = 1'b0;
        pmem_rdata = '0;
        forever begin
            @(posedge clk);
            #1;
            pmem_resp = 1'b0;
            if (!rst && (pmem_read || pmem_write)) begin
                latency = 1 + ($unsigned($random(seed)) % 4);
                repeat (latency - 1) begin
                    @(posedge clk);
                    #1;
                end
                if (pmem_write) begin
                    lines[pmem_address] = pmem_wdata; // rdata keeps the last fill.
                end else if (lines.exists(pmem_address)) begin
                    pmem_rdata = lines[pmem_address];
                end else begin
                    pmem_rdata = fill_line(pmem_address);
                end
                pmem_resp = 1'b1;
            end
        end
    end

endmodule : lower_memory_model

/* testbench/tb_clock.sv */
`timescale 1ns/10ps

module tb_clock #(
    parameter real period = 8.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(period / 2.0) clk = ~clk;
    end

endmodule : tb_clock

/* verilog.f */
verilog/pkg_cache.sv
verilog/cache_way.sv
verilog/cache_datapath.sv
verilog/cache_control.sv
verilog/cache.sv
testbench/tb_clock.sv
testbench/lower_memory_model.sv
testbench/cache_chk.sv
testbench/cache_tb.sv

/* verilog/cache.sv */
`timescale 1ns/10ps

module cache #(
    parameter int addr_w  = 32,
    parameter int line_w  = 256,
    parameter int index_w = 3
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              mem_read,
    input  logic              mem_write,
    input  logic [addr_w-1:0] mem_address,
    input  logic [line_w-1:0] mem_wdata,
    input  logic              pmem_resp,
    input  logic [line_w-1:0] pmem_rdata,
    output logic              mem_resp,
    output logic [line_w-1:0] mem_rdata,
    output logic              pmem_read,
    output logic              pmem_write,
    output logic [addr_w-1:0] pmem_address,
    output logic [line_w-1:0] pmem_wdata
);
    import pkg_cache::*;

    logic       sig_hit;
    logic       sig_dirty;
    logic       ld_valid;
    logic       ld_dirty;
    logic       ld_tag;
    logic       ld_data;
    logic       ld_tmptag;
    logic       ld_tmpdata;
    logic       ld_plru;
    logic       dirty_val;
    dirtywmux_t dirty_wmux;
    datawmux_t  data_wmux;
    datamux_t   data_mux;
    merdmux_t   merd_mux;
    pmadmux_t   pmad_mux;

    cache_control i_control (
        .clk        (clk),
        .rst        (rst),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .pmem_resp  (pmem_resp),
        .sig_hit    (sig_hit),
        .sig_dirty  (sig_dirty),
        .mem_resp   (mem_resp),
        .pmem_read  (pmem_read),
        .pmem_write (pmem_write),
        .ld_valid   (ld_valid),
        .ld_dirty   (ld_dirty),
        .ld_tag     (ld_tag),
        .ld_data    (ld_data),
        .ld_tmptag  (ld_tmptag),
        .ld_tmpdata (ld_tmpdata),
        .ld_plru    (ld_plru),
        .dirty_val  (dirty_val),
        .dirty_wmux (dirty_wmux),
        .data_wmux  (data_wmux),
        .data_mux   (data_mux),
        .merd_mux   (merd_mux),
        .pmad_mux   (pmad_mux)
    );

    cache_datapath #(
        .addr_w  (addr_w),
        .line_w  (line_w),
        .index_w (index_w)
    ) i_datapath (
        .clk          (clk),
        .rst          (rst),
        .mem_address  (mem_address),
        .mem_wdata    (mem_wdata),
        .pmem_rdata   (pmem_rdata),
        .ld_valid     (ld_valid),
        .ld_dirty     (ld_dirty),
        .ld_tag       (ld_tag),
        .ld_data      (ld_data),
        .ld_tmptag    (ld_tmptag),
        .ld_tmpdata   (ld_tmpdata),
        .ld_plru      (ld_plru),
        .dirty_val    (dirty_val),
        .dirty_wmux   (dirty_wmux),
        .data_wmux    (data_wmux),
        .data_mux     (data_mux),
        .merd_mux     (merd_mux),
        .pmad_mux     (pmad_mux),
        .sig_hit      (sig_hit),
        .sig_dirty    (sig_dirty),
        .mem_rdata    (mem_rdata),
        .pmem_address (pmem_address),
        .pmem_wdata   (pmem_wdata)
    );

endmodule : cache

/* verilog/cache_control.sv */
`timescale 1ns/10ps

module cache_control (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  mem_read,
    input  logic                  mem_write,
    input  logic                  pmem_resp,
    input  logic                  sig_hit,
    input  logic                  sig_dirty,
    output logic                  mem_resp,
    output logic                  pmem_read,
    output logic                  pmem_write,
    output logic                  ld_valid,
    output logic                  ld_dirty,
    output logic                  ld_tag,
    output logic                  ld_data,
    output logic                  ld_tmptag,
    output logic                  ld_tmpdata,
    output logic                  ld_plru,
    output logic                  dirty_val,
    output pkg_cache::dirtywmux_t dirty_wmux,
    output pkg_cache::datawmux_t  data_wmux,
    output pkg_cache::datamux_t   data_mux,
    output pkg_cache::merdmux_t   merd_mux,
    output pkg_cache::pmadmux_t   pmad_mux
);
    import pkg_cache::*;

    enum logic [1:0] {IDLE, HIT, MISS, EVICT} state, next_state;

    logic wb_wait; // line installed, victim write-back still running.

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            wb_wait <= 1'b0;
        end else begin
            state   <= next_state;
            wb_wait <= (state == EVICT) && pmem_write && !pmem_resp;
        end
    end

    always_comb begin : next_state_logic
        next_state = state;
        case (state)
            IDLE: begin
                if (mem_read || mem_write) begin
                    next_state = sig_hit ? HIT : MISS;
                end
            end
            HIT: next_state = IDLE;
            MISS: begin
                if (pmem_resp) begin
                    next_state = EVICT;
                end
            end
            EVICT: begin
                // sig_dirty only means the victim until the install edge.
                if (wb_wait ? pmem_resp : (!sig_dirty || pmem_resp)) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end : next_state_logic

    always_comb begin : state_actions
        mem_resp   = 1'b0;
        pmem_read  = 1'b0;
        pmem_write = 1'b0;
        ld_valid   = 1'b0;
        ld_dirty   = 1'b0;
        ld_tag     = 1'b0;
        ld_data    = 1'b0;
        ld_tmptag  = 1'b0;
        ld_tmpdata = 1'b0;
        ld_plru    = 1'b0;
        dirty_val  = 1'b0;
        dirty_wmux = T_HIT;
        data_wmux  = W_HIT;
        data_mux   = D_CPU;
        merd_mux   = M_CACHE;
        pmad_mux   = P_CPU;
        case (state)
            IDLE: begin
            end
            HIT: begin
                mem_resp = 1'b1;
                ld_plru  = 1'b1; // hit way becomes MRU.
                if (mem_write) begin
                    ld_data    = 1'b1;
                    data_wmux  = W_HIT;
                    data_mux   = D_CPU;
                    ld_dirty   = 1'b1;
                    dirty_wmux = T_HIT;
                    dirty_val  = 1'b1;
                end
            end
            MISS: begin
                if (sig_dirty) begin
                    ld_tmptag  = 1'b1;
                    ld_tmpdata = 1'b1;
                end
                pmem_read = 1'b1;
            end
            EVICT: begin
                if (!wb_wait) begin
                    // install once, while pmem_rdata still holds the fill.
                    ld_tag   = 1'b1;
                    ld_valid = 1'b1;
                    ld_plru  = 1'b1;
                    merd_mux = M_LLC;
                    ld_data    = 1'b1;
                    data_wmux  = W_LRU;
                    ld_dirty   = 1'b1;
                    dirty_wmux = T_LRU;
                    if (mem_read) begin
                        data_mux  = D_LLC;
                        dirty_val = 1'b0;
                    end else begin
                        data_mux  = D_CPU;
                        dirty_val = 1'b1;
                    end
                    pmem_write = sig_dirty;
                    mem_resp   = !sig_dirty || pmem_resp;
                end else begin
                    pmem_write = 1'b1; // new line now hits, read it from the way.
                    mem_resp   = pmem_resp;
                end
                if (pmem_write) begin
                    pmad_mux = P_CACHE;
                end
            end
            default: begin
            end
        endcase
    end : state_actions

endmodule : cache_control

/* verilog/cache_datapath.sv */
`timescale 1ns/10ps

module cache_datapath #(
    parameter int addr_w  = 32,
    parameter int line_w  = 256,
    parameter int index_w = 3
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [addr_w-1:0]     mem_address,
    input  logic [line_w-1:0]     mem_wdata,
    input  logic [line_w-1:0]     pmem_rdata,
    input  logic                  ld_valid,
    input  logic                  ld_dirty,
    input  logic                  ld_tag,
    input  logic                  ld_data,
    input  logic                  ld_tmptag,
    input  logic                  ld_tmpdata,
    input  logic                  ld_plru,
    input  logic                  dirty_val,
    input  pkg_cache::dirtywmux_t dirty_wmux,
    input  pkg_cache::datawmux_t  data_wmux,
    input  pkg_cache::datamux_t   data_mux,
    input  pkg_cache::merdmux_t   merd_mux,
    input  pkg_cache::pmadmux_t   pmad_mux,
    output logic                  sig_hit,
    output logic                  sig_dirty,
    output logic [line_w-1:0]     mem_rdata,
    output logic [addr_w-1:0]     pmem_address,
    output logic [line_w-1:0]     pmem_wdata
);
    import pkg_cache::*;

    localparam int offset_w = $clog2(line_w / 8);
    localparam int tag_w    = addr_w - index_w - offset_w;

    logic [tag_w-1:0]        addr_tag;
    logic [index_w-1:0]      addr_index;
    logic [1:0]              way_valid;
    logic [1:0]              way_dirty;
    logic [1:0]              way_hit;
    logic [tag_w-1:0]        way_tag  [2];
    logic [line_w-1:0]       way_data [2];
    logic                    hit_way;
    logic                    lru_way;
    logic                    dirty_way; // way picked by dirty_wmux.
    logic                    data_way;  // way picked by data_wmux.
    logic [2**index_w-1:0]   plru;      // per set, points at the LRU way.
    logic [line_w-1:0]       line_in;
    logic [tag_w-1:0]        tmp_tag;
    logic [line_w-1:0]       tmp_data;

    assign addr_tag   = mem_address[addr_w-1 -: tag_w];
    assign addr_index = mem_address[offset_w +: index_w];

    assign hit_way   = way_hit[1];
    assign lru_way   = plru[addr_index];
    assign dirty_way = (dirty_wmux == T_HIT) ? hit_way : lru_way;
    assign data_way  = (data_wmux == W_HIT) ? hit_way : lru_way;
    assign line_in   = (data_mux == D_CPU) ? mem_wdata : pmem_rdata;

    for (genvar g = 0; g < 2; g++) begin : g_way
        cache_way #(
            .index_w (index_w),
            .tag_w   (tag_w),
            .line_w  (line_w)
        ) i_way (
            .clk      (clk),
            .rst      (rst),
            .index    (addr_index),
            .ld_valid (ld_valid && (data_way == 1'(g))),
            .ld_dirty (ld_dirty && (dirty_way == 1'(g))),
            .ld_tag   (ld_tag && (data_way == 1'(g))),
            .ld_data  (ld_data && (data_way == 1'(g))),
            .dirty_in (dirty_val),
            .tag_in   (addr_tag),
            .data_in  (line_in),
            .valid    (way_valid[g]),
            .dirty    (way_dirty[g]),
            .tag      (way_tag[g]),
            .data     (way_data[g])
        );

        assign way_hit[g] = way_valid[g] && (way_tag[g] == addr_tag);
    end

    assign sig_hit   = |way_hit;
    assign sig_dirty = way_valid[lru_way] && way_dirty[lru_way];

    // touched way becomes MRU.
    always_ff @(posedge clk) begin
        if (rst) begin
            plru <= '0;
        end else if (ld_plru) begin
            plru[addr_index] <= ~dirty_way;
        end
    end

    // victim holding registers.
    always_ff @(posedge clk) begin
        if (ld_tmptag) begin
            tmp_tag <= way_tag[lru_way];
        end
        if (ld_tmpdata) begin
            tmp_data <= way_data[lru_way];
        end
    end

    assign mem_rdata  = (merd_mux == M_CACHE) ? way_data[hit_way] : pmem_rdata;
    assign pmem_wdata = tmp_data;

    // victim shares the set index with the request.
    always_comb begin
        if (pmad_mux == P_CPU) begin
            pmem_address = {addr_tag, addr_index, {offset_w{1'b0}}};
        end else begin
            pmem_address = {tmp_tag, addr_index, {offset_w{1'b0}}};
        end
    end

endmodule : cache_datapath

/* verilog/cache_way.sv */
`timescale 1ns/10ps

module cache_way #(
    parameter int index_w = 3,
    parameter int tag_w   = 24,
    parameter int line_w  = 256
) (
    input  logic               clk,
    input  logic               rst,
    input  logic [index_w-1:0] index,
    input  logic               ld_valid,
    input  logic               ld_dirty,
    input  logic               ld_tag,
    input  logic               ld_data,
    input  logic               dirty_in,
    input  logic [tag_w-1:0]   tag_in,
    input  logic [line_w-1:0]  data_in,
    output logic               valid,
    output logic               dirty,
    output logic [tag_w-1:0]   tag,
    output logic [line_w-1:0]  data
);

    localparam int sets = 2 ** index_w;

    logic [sets-1:0]   valid_q;
    logic [sets-1:0]   dirty_q;
    logic [tag_w-1:0]  tag_q  [sets];
    logic [line_w-1:0] data_q [sets];

    // status bits per set.
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (ld_valid) begin
                valid_q[index] <= 1'b1;
            end
            if (ld_dirty) begin
                dirty_q[index] <= dirty_in;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ld_tag) begin
            tag_q[index] <= tag_in;
        end
        if (ld_data) begin
            data_q[index] <= data_in;
        end
    end

    assign valid = valid_q[index];
    assign dirty = dirty_q[index];
    assign tag   = tag_q[index];
    assign data  = data_q[index];

endmodule : cache_way

/* verilog/pkg_cache.sv */
package pkg_cache;

    // which way's dirty bit gets written.
    // the PLRU update follows the same choice.
    typedef enum logic {
        T_HIT,
        T_LRU
    } dirtywmux_t;

    // which way takes data, tag and valid.
    typedef enum logic {
        W_HIT,
        W_LRU
    } datawmux_t;

    // source of the line written into a way.
    typedef enum logic {
        D_CPU,
        D_LLC
    } datamux_t;

    // source of mem_rdata.
    typedef enum logic {
        M_CACHE,
        M_LLC
    } merdmux_t;

    // source of pmem_address.
    typedef enum logic {
        P_CPU,
        P_CACHE
    } pmadmux_t;

endpackage : pkg_cache
